/* hw/fetch_pkg.sv */
package fetch_pkg;

	// widths of the fetch datapath and of the instruction memory port
	localparam int addr_w = 64;
	localparam int data_w = 64;
	localparam int inst_w = 32;
	localparam int resp_w = 2;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] data_t;
	typedef logic [inst_w-1:0] inst_t;
	typedef logic [resp_w-1:0] resp_t;

	// any other response code is treated as an access fault
	localparam resp_t resp_okay = 2'b00;

	// one slot of the fetch buffer, as seen by decode
	typedef struct packed {
		addr_t pc;
		inst_t inst;
		logic  fault;
	} fetch_entry_t;

endpackage

/* hw/isa_pkg.sv */
package isa_pkg;

	// address of the first fetch after reset
	localparam fetch_pkg::addr_t reset_vector = 64'h0000_0000_8000_0000;

	// no compressed instructions, so the PC always steps by one word
	localparam fetch_pkg::addr_t inst_bytes = 64'd4;

	// a squashed slot carries this all-zero word, which decode treats as a bubble
	localparam fetch_pkg::inst_t bubble_inst = 32'h0000_0000;

endpackage

/* hw/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen #(
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_pc,
	input  logic             pop,
	output logic             req,
	output fetch_pkg::addr_t req_addr,
	output logic             tag_push,
	output logic             tag
);

	localparam int CNT_W = $clog2(DEPTH + 1);

	fetch_pkg::addr_t pc;
	logic             epoch;
	logic             run;
	logic [CNT_W-1:0] credit;

	// credit covers every request in flight plus every entry still held in the
	// instruction buffer, so neither buffer can overflow
	assign req = run && !redirect && (credit < CNT_W'(DEPTH));

	assign req_addr = pc;

	// every request leaves its epoch behind in the tag buffer
	assign tag_push = req;
	assign tag      = epoch;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc    <= isa_pkg::reset_vector;
			epoch <= 1'b0;
			run   <= 1'b0;
		end else begin
			// fetch starts one cycle after reset is released
			run <= 1'b1;
			if (redirect) begin
				pc    <= redirect_pc;
				epoch <= ~epoch;
			end else if (req) begin
				pc <= pc + isa_pkg::inst_bytes;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			credit <= '0;
		end else begin
			case ({req, pop})
				2'b10: begin
					credit <= credit + 1'b1;
				end
				2'b01: begin
					credit <= credit - 1'b1;
				end
				default: begin
					credit <= credit;
				end
			endcase
		end
	end

	// the decode side can only pop what was requested before
	a_credit_bound: assert property (
		@(posedge clk) disable iff (reset)
		credit <= CNT_W'(DEPTH)
	) else $error("pc_gen: credit count %0d exceeds DEPTH %0d", credit, DEPTH);

endmodule

/* hw/fetch_resp.sv */
`timescale 1ns/1ps

module fetch_resp (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    r_valid,
	input  fetch_pkg::data_t        r_data,
	input  fetch_pkg::addr_t        r_addr,
	input  fetch_pkg::resp_t        resp,
	input  logic                    tag_empty,
	input  logic                    tag,
	input  logic                    redirect,
	output logic                    tag_pop,
	output logic                    push,
	output fetch_pkg::fetch_entry_t entry
);

	logic             epoch;
	logic             stale;
	fetch_pkg::inst_t word;

	// local copy of the epoch, kept in step with the one in pc_gen
	always_ff @(posedge clk) begin
		if (reset) begin
			epoch <= 1'b0;
		end else if (redirect) begin
			epoch <= ~epoch;
		end
	end

	// a response in the redirect cycle already belongs to the old path
	assign stale = (tag != (epoch ^ redirect));

	// the beat holds two words, address bit 2 picks the upper one
	assign word = r_addr[2] ? r_data[63:32] : r_data[31:0];

	// each response consumes its tag and always produces one slot
	assign tag_pop = r_valid;
	assign push    = r_valid;

	always_comb begin
		entry.pc    = r_addr;
		entry.inst  = word;
		entry.fault = 1'b0;
		if (stale) begin
			entry.inst = isa_pkg::bubble_inst;
		end else if (resp != fetch_pkg::resp_okay) begin
			entry.inst  = isa_pkg::bubble_inst;
			entry.fault = 1'b1;
		end
	end

	// memory only answers requests that pc_gen has tagged
	a_resp_tagged: assert property (
		@(posedge clk) disable iff (reset)
		r_valid |-> !tag_empty
	) else $error("fetch_resp: response without an outstanding request");

endmodule

/* hw/fetch_fifo.sv */
`timescale 1ns/1ps

module fetch_fifo #(
	parameter int DEPTH = 4,
	parameter type entry_t = logic
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   push,
	input  entry_t push_data,
	input  logic   pop,
	output entry_t pop_data,
	output logic   empty,
	output logic   full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	entry_t           mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;

	// pointers wrap explicitly so that DEPTH need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign empty    = (count == '0);
	assign full     = (count == CNT_W'(DEPTH));
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

	// the credit scheme upstream is what keeps both of these quiet
	a_no_overflow: assert property (
		@(posedge clk) disable iff (reset)
		push |-> !full
	) else $error("fetch_fifo: push while full");

	a_no_underflow: assert property (
		@(posedge clk) disable iff (reset)
		pop |-> !empty
	) else $error("fetch_fifo: pop while empty");

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    empty,
	input  fetch_pkg::fetch_entry_t head,
	input  logic                    ready,
	output logic                    pop,
	output logic                    out_valid,
	output fetch_pkg::addr_t        out_pc,
	output fetch_pkg::inst_t        out_inst,
	output fetch_pkg::addr_t        out_snpc,
	output logic                    out_fault
);

	// take the next slot when the register is free or being drained this cycle
	assign pop = !empty && (!out_valid || ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (pop) begin
			out_valid <= 1'b1;
		end else if (ready) begin
			out_valid <= 1'b0;
		end
	end

	// payload only moves on a pop, so it holds while decode stalls
	always_ff @(posedge clk) begin
		if (pop) begin
			out_pc    <= head.pc;
			out_inst  <= head.inst;
			out_fault <= head.fault;
		end
	end

	// sequential next PC, no compressed instructions
	assign out_snpc = out_pc + isa_pkg::inst_bytes;

	// decode may sample at any point of a stall and must see the same slot
	a_hold_on_stall: assert property (
		@(posedge clk) disable iff (reset)
		(out_valid && !ready) |=>
			(out_valid && $stable(out_pc) && $stable(out_inst) && $stable(out_fault))
	) else $error("fetch_stage: outputs changed while stalled");

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_pc,
	input  logic             r_valid,
	input  fetch_pkg::data_t r_data,
	input  fetch_pkg::addr_t r_addr,
	input  fetch_pkg::resp_t resp,
	input  logic             ready,
	output logic             req,
	output fetch_pkg::addr_t req_addr,
	output logic             out_valid,
	output fetch_pkg::addr_t out_pc,
	output fetch_pkg::inst_t out_inst,
	output fetch_pkg::addr_t out_snpc,
	output logic             out_fault
);

	logic                    tag_push;
	logic                    tag_in;
	logic                    tag_pop;
	logic                    tag_head;
	logic                    tag_empty;
	logic                    inst_push;
	logic                    inst_pop;
	logic                    inst_empty;
	fetch_pkg::fetch_entry_t inst_entry;
	fetch_pkg::fetch_entry_t inst_head;

	pc_gen #(
		.DEPTH(DEPTH)
	) pc_gen0 (
		.clk        (clk),
		.reset      (reset),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.pop        (inst_pop),
		.req        (req),
		.req_addr   (req_addr),
		.tag_push   (tag_push),
		.tag        (tag_in)
	);

	// epoch of every request still waiting for its response
	fetch_fifo #(
		.DEPTH  (DEPTH),
		.entry_t(logic)
	) tag_fifo (
		.clk      (clk),
		.reset    (reset),
		.push     (tag_push),
		.push_data(tag_in),
		.pop      (tag_pop),
		.pop_data (tag_head),
		.empty    (tag_empty),
		.full     ()
	);

	fetch_resp fetch_resp0 (
		.clk      (clk),
		.reset    (reset),
		.r_valid  (r_valid),
		.r_data   (r_data),
		.r_addr   (r_addr),
		.resp     (resp),
		.tag_empty(tag_empty),
		.tag      (tag_head),
		.redirect (redirect),
		.tag_pop  (tag_pop),
		.push     (inst_push),
		.entry    (inst_entry)
	);

	fetch_fifo #(
		.DEPTH  (DEPTH),
		.entry_t(fetch_pkg::fetch_entry_t)
	) inst_fifo (
		.clk      (clk),
		.reset    (reset),
		.push     (inst_push),
		.push_data(inst_entry),
		.pop      (inst_pop),
		.pop_data (inst_head),
		.empty    (inst_empty),
		.full     ()
	);

	fetch_stage fetch_stage0 (
		.clk      (clk),
		.reset    (reset),
		.empty    (inst_empty),
		.head     (inst_head),
		.ready    (ready),
		.pop      (inst_pop),
		.out_valid(out_valid),
		.out_pc   (out_pc),
		.out_inst (out_inst),
		.out_snpc (out_snpc),
		.out_fault(out_fault)
	);

endmodule

/* sim/tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch;

	localparam int depth = 4;
	localparam int n_entries = 200;
	localparam int cycle_limit = 20 * n_entries;
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;

	logic clk;
	logic reset;
	logic redirect;
	fetch_pkg::addr_t redirect_pc;
	logic r_valid;
	fetch_pkg::data_t r_data;
	fetch_pkg::addr_t r_addr;
	fetch_pkg::resp_t resp;
	logic ready;
	logic req;
	fetch_pkg::addr_t req_addr;
	logic out_valid;
	fetch_pkg::addr_t out_pc;
	fetch_pkg::inst_t out_inst;
	fetch_pkg::addr_t out_snpc;
	logic out_fault;

	logic [31:0] lfsr_state = 32'h2939_fe4f;
	int cycles = 0;
	int checks = 0;
	int mismatches = 0;
	int other_errors = 0;
	int issued = 0;
	int transfers = 0;
	int redirect_count = 0;
	int last_due = 0;
	int stall_left = 0;
	bit seen_req = 1'b0;
	fetch_pkg::addr_t next_req_addr = isa_pkg::reset_vector;

	// memory model: requests waiting for their response, oldest first
	fetch_pkg::addr_t pend_addr[$];
	int pend_due[$];
	int pend_gen[$];
	fetch_pkg::fetch_entry_t expected[$];

	fetch_top #(
		.DEPTH(depth)
	) dut0 (
		.clk        (clk),
		.reset      (reset),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.r_valid    (r_valid),
		.r_data     (r_data),
		.r_addr     (r_addr),
		.resp       (resp),
		.ready      (ready),
		.req        (req),
		.req_addr   (req_addr),
		.out_valid  (out_valid),
		.out_pc     (out_pc),
		.out_inst   (out_inst),
		.out_snpc   (out_snpc),
		.out_fault  (out_fault)
	);

	always #2 clk = ~clk;

	// galois LFSR, one step per bit handed out
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
		end
		return value;
	endfunction

	// every memory word is its own address scrambled with a constant
	function automatic fetch_pkg::inst_t word_for(input fetch_pkg::addr_t addr);
		return addr[31:0] ^ 32'h3c5a_96e1;
	endfunction

	function automatic fetch_pkg::data_t beat_for(input fetch_pkg::addr_t addr);
		fetch_pkg::addr_t base;
		base = {addr[63:3], 3'b000};
		return {word_for(base + 64'd4), word_for(base)};
	endfunction

	// one word in sixteen answers with an access fault
	function automatic fetch_pkg::resp_t resp_for(input fetch_pkg::addr_t addr);
		return (addr[5:2] == 4'hb) ? 2'b10 : 2'b00;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
		checks = checks + 1;
		assert (got === want) else begin
			mismatches = mismatches + 1;
			$display("MISMATCH %s: expected %h, got %h at cycle %0d", name, want, got, cycles);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks = checks + 1;
		assert (cond) else begin
			other_errors = other_errors + 1;
			$display("error at cycle %0d: %s", cycles, what);
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] offset;
		if (pend_due.size() > 0 && pend_due[0] <= cycles) begin
			r_valid = 1'b1;
			r_addr  = pend_addr[0];
			r_data  = beat_for(pend_addr[0]);
			resp    = resp_for(pend_addr[0]);
		end else begin
			r_valid = 1'b0;
			r_addr  = '0;
			r_data  = '0;
			resp    = '0;
		end
		// decode stalls come in stretches of one to eight cycles
		if (stall_left > 0) begin
			ready = 1'b0;
			stall_left = stall_left - 1;
		end else if (lfsr_bits(3) == 0) begin
			ready = 1'b0;
			stall_left = lfsr_bits(3);
		end else begin
			ready = 1'b1;
		end
		// redirects start once the first fetch from the reset vector is out
		if (seen_req && lfsr_bits(5) == 0) begin
			offset = lfsr_bits(10);
			redirect = 1'b1;
			redirect_pc = isa_pkg::reset_vector + (fetch_pkg::addr_t'(offset) << 2);
		end else begin
			redirect = 1'b0;
		end
	endtask

	task automatic finish_run(input bit timed_out);
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
		if (!timed_out && mismatches == 0 && other_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	// monitor, memory request capture and scoreboard, all sampled before the edge updates
	always @(posedge clk) begin
		fetch_pkg::fetch_entry_t want;
		int due;
		int in_use;
		if (!reset) begin
			in_use = issued - transfers - (out_valid ? 1 : 0);
			check_true(in_use <= depth, "more than DEPTH slots in use");
			check_true(!(req && redirect), "request issued in the redirect cycle");
			if (redirect) begin
				redirect_count = redirect_count + 1;
				next_req_addr = redirect_pc;
			end
			if (req) begin
				check_true(in_use < depth, "request issued with all DEPTH slots taken");
				if (!seen_req) begin
					check_value("req_addr", req_addr, isa_pkg::reset_vector);
				end
				check_value("req_addr", req_addr, next_req_addr);
				seen_req = 1'b1;
				due = cycles + 1 + int'(lfsr_bits(2));
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				pend_addr.push_back(req_addr);
				pend_due.push_back(due);
				pend_gen.push_back(redirect_count);
				next_req_addr = req_addr + 64'd4;
				issued = issued + 1;
			end
			if (r_valid) begin
				want.pc = pend_addr.pop_front();
				void'(pend_due.pop_front());
				want.inst = isa_pkg::bubble_inst;
				want.fault = 1'b0;
				// a redirect since the request, this cycle included, squashes it
				if (pend_gen.pop_front() == redirect_count) begin
					if (resp_for(want.pc) != 2'b00) begin
						want.fault = 1'b1;
					end else begin
						want.inst = word_for(want.pc);
					end
				end
				expected.push_back(want);
			end
			if (out_valid && ready) begin
				check_true(expected.size() > 0, "output with no expected entry");
				if (expected.size() > 0) begin
					want = expected.pop_front();
					check_value("out_pc", out_pc, want.pc);
					check_value("out_inst", 64'(out_inst), 64'(want.inst));
					check_value("out_fault", 64'(out_fault), 64'(want.fault));
					check_value("out_snpc", out_snpc, want.pc + 64'd4);
				end
				transfers = transfers + 1;
			end
		end
		cycles = cycles + 1;
	end

	hold_on_stall: assert property (
		@(posedge clk) disable iff (reset)
		(out_valid && !ready) |=>
			(out_valid && $stable(out_pc) && $stable(out_inst) && $stable(out_fault))
	) else begin
		other_errors = other_errors + 1;
		$display("error at cycle %0d: outputs changed while decode stalled", cycles);
	end

	initial begin
		wait (cycles >= cycle_limit);
		$display("timeout after %0d cycles with %0d of %0d entries out", cycles, transfers,
			n_entries);
		finish_run(1'b1);
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		r_valid = 1'b0;
		r_data = '0;
		r_addr = '0;
		resp = '0;
		ready = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(posedge clk);
		check_true(!req && !out_valid, "req or out_valid high right after reset");
		while (transfers < n_entries) begin
			@(negedge clk);
			drive_inputs();
		end
		finish_run(1'b0);
	end

endmodule

/* src.f */
hw/fetch_pkg.sv
hw/isa_pkg.sv
hw/pc_gen.sv
hw/fetch_resp.sv
hw/fetch_fifo.sv
hw/fetch_stage.sv
hw/fetch_top.sv
sim/tb_fetch.sv

/* Bender.yml */
package:
  name: fetch_front_end

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/isa_pkg.sv
      - hw/pc_gen.sv
      - hw/fetch_resp.sv
      - hw/fetch_fifo.sv
      - hw/fetch_stage.sv
      - hw/fetch_top.sv
  - target: simulation
    files:
      - sim/tb_fetch.sv
